// ==== flist.f ====
hdl/mst_if_pkg.sv
hdl/chan_fifo.sv
hdl/req_path.sv
hdl/rsp_path.sv
hdl/axi_mst_if.sv
bench/tb_axi_mst_if.sv

// ==== Makefile ====
# Verilator build, run and lint for the AXI master port

VERILATOR ?= verilator
TOP       ?= tb_axi_mst_if
RTL_TOP   ?= axi_mst_if
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SRCS     := $(shell grep -v '^+' $(FLIST))
RTL_SRCS := $(filter hdl/%,$(SRCS))
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_axi_mst_if.sv ====
// Drives table traffic through the AXI master port and a simple slave model
// with random switch-side stalls, then an AW back-pressure run; built by the Makefile
module tb_axi_mst_if;

    import mst_if_pkg::*;

    localparam int OSTD_NUM = 4;
    localparam int TIMEOUT  = 200;
    localparam int N_ENT    = 10;

    // Masks over the status vector below
    localparam logic [9:0] SW_AW       = 10'h001;
    localparam logic [9:0] SW_W        = 10'h002;
    localparam logic [9:0] SW_AR       = 10'h004;
    localparam logic [9:0] M_AW        = 10'h008;
    localparam logic [9:0] M_W         = 10'h010;
    localparam logic [9:0] M_AR        = 10'h020;
    localparam logic [9:0] M_B         = 10'h040;
    localparam logic [9:0] M_R         = 10'h080;
    localparam logic [9:0] SW_B        = 10'h100;
    localparam logic [9:0] SW_R        = 10'h200;
    localparam logic [9:0] RESET_FLAGS = 10'h0c7;

    typedef struct packed {
        logic                  wr;
        logic [AXI_ADDR_W-1:0] addr;
        logic [2:0]            prot;
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic [1:0]            resp;
    } entry_t;

    logic                  i_aclk = 1'b0;
    logic                  i_reset;
    logic                  i_sw_awvalid, o_sw_awready, i_sw_wvalid, o_sw_wready;
    logic                  o_sw_bvalid, i_sw_bready, i_sw_arvalid, o_sw_arready;
    logic                  o_sw_rvalid, i_sw_rready;
    ax_chan_t              i_sw_aw, i_sw_ar;
    w_chan_t               i_sw_w;
    b_chan_t               o_sw_b;
    r_chan_t               o_sw_r;
    logic                  o_m_awvalid, i_m_awready, o_m_wvalid, i_m_wready, o_m_wlast;
    logic                  i_m_bvalid, o_m_bready, o_m_arvalid, i_m_arready;
    logic                  i_m_rvalid, o_m_rready;
    logic [AXI_ADDR_W-1:0] o_m_awaddr, o_m_araddr;
    logic [2:0]            o_m_awprot, o_m_arprot;
    logic [AXI_ID_W-1:0]   o_m_awid, o_m_arid, i_m_bid, i_m_rid;
    logic [AXI_DATA_W-1:0] o_m_wdata, i_m_rdata;
    logic [AXI_STRB_W-1:0] o_m_wstrb;
    logic [1:0]            i_m_bresp, i_m_rresp;
    logic [9:0]            flags;

    int err_cnt     = 0;
    int timeout_cnt = 0;
    int n_acc;
    int wr_idx [$];
    int rd_idx [$];

    // wr, addr, prot, id, data, strb, slave response
    entry_t tbl [N_ENT] = '{
        '{1'b1, 16'h1000, 3'd0, 4'h1, 32'hdead_beef, 4'hf, RESP_OKAY},
        '{1'b0, 16'h2000, 3'd1, 4'h2, 32'h1234_5678, 4'h0, RESP_OKAY},
        '{1'b1, 16'h1004, 3'd2, 4'h3, 32'ha5a5_5a5a, 4'h3, RESP_EXOKAY},
        '{1'b1, 16'h1008, 3'd3, 4'h4, 32'h0000_ffff, 4'hc, RESP_SLVERR},
        '{1'b0, 16'h2004, 3'd4, 4'h5, 32'hcafe_f00d, 4'h0, RESP_DECERR},
        '{1'b1, 16'h100c, 3'd5, 4'h6, 32'h8765_4321, 4'h1, RESP_OKAY},
        '{1'b0, 16'h2008, 3'd6, 4'h7, 32'h0bad_c0de, 4'h0, RESP_SLVERR},
        '{1'b1, 16'h1010, 3'd7, 4'h8, 32'hffff_0000, 4'h8, RESP_DECERR},
        '{1'b1, 16'h1014, 3'd0, 4'h9, 32'h1357_9bdf, 4'hf, RESP_OKAY},
        '{1'b0, 16'h200c, 3'd2, 4'ha, 32'h2468_ace0, 4'h0, RESP_EXOKAY}
    };
    string tbl_name [N_ENT] = '{"wr0_okay", "rd1_okay", "wr2_exokay", "wr3_slverr",
        "rd4_decerr", "wr5_okay", "rd6_slverr", "wr7_decerr", "wr8_okay", "rd9_exokay"};

    axi_mst_if DUT (.*);

    always #4 i_aclk = ~i_aclk;

    assign flags = {o_sw_rvalid, o_sw_bvalid, o_m_rready, o_m_bready, o_m_arvalid,
                    o_m_wvalid, o_m_awvalid, o_sw_arready, o_sw_wready, o_sw_awready};

    ////////////////////
    // Helpers
    ////////////////////

    task automatic finish_run();
        $display("Run ended with %0d errors and %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // Returns on the falling edge where all masked flags are high
    task automatic wait_for(input logic [9:0] mask, input bit stall, input string what);
        for (int cyc = 0; cyc < TIMEOUT; cyc++) begin
            @(negedge i_aclk);
            if ((flags & mask) == mask && (!stall || $urandom_range(2) == 0)) begin
                return;
            end
        end
        timeout_cnt++;
        $display("Timed out waiting for %s", what);
        finish_run();
    endtask

    task automatic check_ax(input string name, input ax_chan_t exp, input ax_chan_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERROR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_w(input string name, input w_chan_t exp, input w_chan_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERROR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_b(input string name, input b_chan_t exp, input b_chan_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERROR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_r(input string name, input r_chan_t exp, input r_chan_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERROR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    // Back-pressure words with distinct fields
    function automatic ax_chan_t bp_word(input int n);
        return ax_chan_t'{16'h4000 + 16'(n * 4), 3'(n), 4'(n + 8)};
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        void'($urandom(32'hf4a6));
        i_reset = 1'b1;
        {i_sw_awvalid, i_sw_wvalid, i_sw_arvalid, i_sw_bready, i_sw_rready} = '0;
        {i_m_awready, i_m_wready, i_m_arready, i_m_bvalid, i_m_rvalid} = '0;
        {i_m_bid, i_m_bresp, i_m_rid, i_m_rdata, i_m_rresp} = '0;
        i_sw_aw = '0;
        i_sw_ar = '0;
        i_sw_w  = '0;
        repeat (3) @(negedge i_aclk);
        i_reset = 1'b0;
        @(negedge i_aclk);
        if (flags !== RESET_FLAGS) begin
            err_cnt++;
            $display("ERROR reset_state: expected %h actual %h", RESET_FLAGS, flags);
        end
        foreach (tbl[i]) begin
            if (tbl[i].wr) begin
                wr_idx.push_back(i);
            end else begin
                rd_idx.push_back(i);
            end
        end

        fork
            // Switch side issues requests in table order
            foreach (tbl[i]) begin
                if (tbl[i].wr) begin
                    wait_for(SW_AW | SW_W, 1'b0, "AW and W ready at switch");
                    i_sw_aw      = ax_chan_t'{tbl[i].addr, tbl[i].prot, tbl[i].id};
                    i_sw_w       = w_chan_t'{tbl[i].data, tbl[i].strb, 1'b1};
                    i_sw_awvalid = 1'b1;
                    i_sw_wvalid  = 1'b1;
                    @(negedge i_aclk);
                    i_sw_awvalid = 1'b0;
                    i_sw_wvalid  = 1'b0;
                end else begin
                    wait_for(SW_AR, 1'b0, "AR ready at switch");
                    i_sw_ar      = ax_chan_t'{tbl[i].addr, tbl[i].prot, tbl[i].id};
                    i_sw_arvalid = 1'b1;
                    @(negedge i_aclk);
                    i_sw_arvalid = 1'b0;
                end
            end
            // Write side of the slave model
            foreach (wr_idx[k]) begin
                entry_t e;
                e = tbl[wr_idx[k]];
                wait_for(M_AW | M_W, 1'b0, "write at slave");
                check_ax(tbl_name[wr_idx[k]], ax_chan_t'{e.addr, e.prot, e.id},
                         ax_chan_t'{o_m_awaddr, o_m_awprot, o_m_awid});
                check_w(tbl_name[wr_idx[k]], w_chan_t'{e.data, e.strb, 1'b1},
                        w_chan_t'{o_m_wdata, o_m_wstrb, o_m_wlast});
                i_m_awready = 1'b1;
                i_m_wready  = 1'b1;
                @(negedge i_aclk);
                i_m_awready = 1'b0;
                i_m_wready  = 1'b0;
                wait_for(M_B, 1'b0, "B ready at slave");
                i_m_bid    = e.id;
                i_m_bresp  = e.resp;
                i_m_bvalid = 1'b1;
                @(negedge i_aclk);
                i_m_bvalid = 1'b0;
            end
            // Read side of the slave model
            foreach (rd_idx[k]) begin
                entry_t e;
                e = tbl[rd_idx[k]];
                wait_for(M_AR, 1'b0, "read at slave");
                check_ax(tbl_name[rd_idx[k]], ax_chan_t'{e.addr, e.prot, e.id},
                         ax_chan_t'{o_m_araddr, o_m_arprot, o_m_arid});
                i_m_arready = 1'b1;
                @(negedge i_aclk);
                i_m_arready = 1'b0;
                wait_for(M_R, 1'b0, "R ready at slave");
                i_m_rid    = e.id;
                i_m_rdata  = e.data;
                i_m_rresp  = e.resp;
                i_m_rvalid = 1'b1;
                @(negedge i_aclk);
                i_m_rvalid = 1'b0;
            end
            // Switch takes responses with random stalls
            foreach (wr_idx[k]) begin
                wait_for(SW_B, 1'b1, "B at switch");
                check_b(tbl_name[wr_idx[k]],
                        b_chan_t'{tbl[wr_idx[k]].id, tbl[wr_idx[k]].resp}, o_sw_b);
                i_sw_bready = 1'b1;
                @(negedge i_aclk);
                i_sw_bready = 1'b0;
            end
            foreach (rd_idx[k]) begin
                entry_t e;
                e = tbl[rd_idx[k]];
                wait_for(SW_R, 1'b1, "R at switch");
                check_r(tbl_name[rd_idx[k]], r_chan_t'{e.id, e.data, e.resp, 1'b1}, o_sw_r);
                i_sw_rready = 1'b1;
                @(negedge i_aclk);
                i_sw_rready = 1'b0;
            end
        join

        // Every channel drained, no word left over
        if (flags !== RESET_FLAGS) begin
            err_cnt++;
            $display("ERROR idle_state: expected %h actual %h", RESET_FLAGS, flags);
        end

        // Slave holds AW ready low while the switch pushes
        n_acc = 0;
        @(negedge i_aclk);
        while (o_sw_awready && n_acc <= OSTD_NUM) begin
            i_sw_aw      = bp_word(n_acc);
            i_sw_awvalid = 1'b1;
            n_acc++;
            @(negedge i_aclk);
        end
        i_sw_awvalid = 1'b0;
        if (n_acc != OSTD_NUM) begin
            err_cnt++;
            $display("ERROR aw_backpressure: expected %0d actual %0d", OSTD_NUM, n_acc);
        end
        for (int n = 0; n < n_acc; n++) begin
            wait_for(M_AW, 1'b0, "AW drain at slave");
            check_ax("aw_drain", bp_word(n), ax_chan_t'{o_m_awaddr, o_m_awprot, o_m_awid});
            i_m_awready = 1'b1;
            @(negedge i_aclk);
            i_m_awready = 1'b0;
        end
        finish_run();
    end

endmodule

// ==== hdl/axi_mst_if.sv ====
// Buffered master-side port of the AXI crossbar, switch words in and
// AXI4-lite signals out to the slave; instantiate once per slave port
module axi_mst_if #(
    parameter int OSTD_NUM  = 4,
    parameter int OSTD_SIZE = 1
) (
    input  logic                                i_aclk,
    input  logic                                i_reset,
    // Switch side
    input  logic                                i_sw_awvalid,
    output logic                                o_sw_awready,
    input  mst_if_pkg::ax_chan_t                i_sw_aw,
    input  logic                                i_sw_wvalid,
    output logic                                o_sw_wready,
    input  mst_if_pkg::w_chan_t                 i_sw_w,
    output logic                                o_sw_bvalid,
    input  logic                                i_sw_bready,
    output mst_if_pkg::b_chan_t                 o_sw_b,
    input  logic                                i_sw_arvalid,
    output logic                                o_sw_arready,
    input  mst_if_pkg::ax_chan_t                i_sw_ar,
    output logic                                o_sw_rvalid,
    input  logic                                i_sw_rready,
    output mst_if_pkg::r_chan_t                 o_sw_r,
    // Slave side, AXI4-lite
    output logic                                o_m_awvalid,
    input  logic                                i_m_awready,
    output logic [mst_if_pkg::AXI_ADDR_W-1:0]   o_m_awaddr,
    output logic [2:0]                          o_m_awprot,
    output logic [mst_if_pkg::AXI_ID_W-1:0]     o_m_awid,
    output logic                                o_m_wvalid,
    input  logic                                i_m_wready,
    output logic [mst_if_pkg::AXI_DATA_W-1:0]   o_m_wdata,
    output logic [mst_if_pkg::AXI_STRB_W-1:0]   o_m_wstrb,
    output logic                                o_m_wlast,
    input  logic                                i_m_bvalid,
    output logic                                o_m_bready,
    input  logic [mst_if_pkg::AXI_ID_W-1:0]     i_m_bid,
    input  logic [1:0]                          i_m_bresp,
    output logic                                o_m_arvalid,
    input  logic                                i_m_arready,
    output logic [mst_if_pkg::AXI_ADDR_W-1:0]   o_m_araddr,
    output logic [2:0]                          o_m_arprot,
    output logic [mst_if_pkg::AXI_ID_W-1:0]     o_m_arid,
    input  logic                                i_m_rvalid,
    output logic                                o_m_rready,
    input  logic [mst_if_pkg::AXI_ID_W-1:0]     i_m_rid,
    input  logic [mst_if_pkg::AXI_DATA_W-1:0]   i_m_rdata,
    input  logic [1:0]                          i_m_rresp
);

    ////////////////////
    // Request direction
    ////////////////////

    // Port names match one to one, so connect by name
    req_path #(
        .OSTD_NUM  (OSTD_NUM),
        .OSTD_SIZE (OSTD_SIZE)
    ) u_req (.*);

    ////////////////////
    // Response direction
    ////////////////////

    rsp_path #(
        .OSTD_NUM  (OSTD_NUM),
        .OSTD_SIZE (OSTD_SIZE)
    ) u_rsp (.*);

endmodule

// ==== hdl/rsp_path.sv ====
// Response direction of the master port: packs the slave's B and R signals
// into channel words and buffers them toward the switch
module rsp_path #(
    parameter int OSTD_NUM  = 4,
    parameter int OSTD_SIZE = 1
) (
    input  logic                                i_aclk,
    input  logic                                i_reset,
    // Slave side
    input  logic                                i_m_bvalid,
    output logic                                o_m_bready,
    input  logic [mst_if_pkg::AXI_ID_W-1:0]     i_m_bid,
    input  logic [1:0]                          i_m_bresp,
    input  logic                                i_m_rvalid,
    output logic                                o_m_rready,
    input  logic [mst_if_pkg::AXI_ID_W-1:0]     i_m_rid,
    input  logic [mst_if_pkg::AXI_DATA_W-1:0]   i_m_rdata,
    input  logic [1:0]                          i_m_rresp,
    // Switch side
    output logic                                o_sw_bvalid,
    input  logic                                i_sw_bready,
    output mst_if_pkg::b_chan_t                 o_sw_b,
    output logic                                o_sw_rvalid,
    input  logic                                i_sw_rready,
    output mst_if_pkg::r_chan_t                 o_sw_r
);

    import mst_if_pkg::*;

    localparam int B_DEPTH = OSTD_NUM;
    localparam int R_DEPTH = OSTD_NUM * OSTD_SIZE;

    b_chan_t b_in;
    r_chan_t r_in;
    logic    b_full;
    logic    b_empty;
    logic    r_full;
    logic    r_empty;

    ////////////////////
    // Write response
    ////////////////////

    assign b_in.id   = i_m_bid;
    assign b_in.resp = i_m_bresp;

    chan_fifo #(.DATA_W($bits(b_chan_t)), .DEPTH(B_DEPTH)) b_fifo (
        .i_aclk  (i_aclk),
        .i_reset (i_reset),
        .i_push  (i_m_bvalid),
        .i_data  (b_in),
        .o_full  (b_full),
        .i_pull  (i_sw_bready),
        .o_data  (o_sw_b),
        .o_empty (b_empty)
    );

    assign o_m_bready  = ~b_full;
    assign o_sw_bvalid = ~b_empty;

    ////////////////////
    // Read data
    ////////////////////

    assign r_in.id   = i_m_rid;
    assign r_in.data = i_m_rdata;
    assign r_in.resp = i_m_rresp;
    // Lite slave gives no rlast, every beat ends its burst
    assign r_in.last = 1'b1;

    chan_fifo #(.DATA_W($bits(r_chan_t)), .DEPTH(R_DEPTH)) r_fifo (
        .i_aclk  (i_aclk),
        .i_reset (i_reset),
        .i_push  (i_m_rvalid),
        .i_data  (r_in),
        .o_full  (r_full),
        .i_pull  (i_sw_rready),
        .o_data  (o_sw_r),
        .o_empty (r_empty)
    );

    assign o_m_rready  = ~r_full;
    assign o_sw_rvalid = ~r_empty;

    // Switch-side valids come out of reset defined and stay so
    a_valid_known: assert property (@(posedge i_aclk) disable iff (i_reset)
        !$isunknown({o_sw_bvalid, o_sw_rvalid}));

endmodule

// ==== hdl/req_path.sv ====
// Request direction of the master port: buffers AW, W and AR toward the slave
// and splits each buffered word into AXI4-lite signals
module req_path #(
    parameter int OSTD_NUM  = 4,
    parameter int OSTD_SIZE = 1
) (
    input  logic                                i_aclk,
    input  logic                                i_reset,
    // Switch side
    input  logic                                i_sw_awvalid,
    output logic                                o_sw_awready,
    input  mst_if_pkg::ax_chan_t                i_sw_aw,
    input  logic                                i_sw_wvalid,
    output logic                                o_sw_wready,
    input  mst_if_pkg::w_chan_t                 i_sw_w,
    input  logic                                i_sw_arvalid,
    output logic                                o_sw_arready,
    input  mst_if_pkg::ax_chan_t                i_sw_ar,
    // Slave side
    output logic                                o_m_awvalid,
    input  logic                                i_m_awready,
    output logic [mst_if_pkg::AXI_ADDR_W-1:0]   o_m_awaddr,
    output logic [2:0]                          o_m_awprot,
    output logic [mst_if_pkg::AXI_ID_W-1:0]     o_m_awid,
    output logic                                o_m_wvalid,
    input  logic                                i_m_wready,
    output logic [mst_if_pkg::AXI_DATA_W-1:0]   o_m_wdata,
    output logic [mst_if_pkg::AXI_STRB_W-1:0]   o_m_wstrb,
    output logic                                o_m_wlast,
    output logic                                o_m_arvalid,
    input  logic                                i_m_arready,
    output logic [mst_if_pkg::AXI_ADDR_W-1:0]   o_m_araddr,
    output logic [2:0]                          o_m_arprot,
    output logic [mst_if_pkg::AXI_ID_W-1:0]     o_m_arid
);

    import mst_if_pkg::*;

    // Address channels hold one word per request, W one per beat
    localparam int AX_DEPTH = OSTD_NUM;
    localparam int W_DEPTH  = OSTD_NUM * OSTD_SIZE;

    ax_chan_t aw_q;
    ax_chan_t ar_q;
    w_chan_t  w_q;
    logic     aw_full;
    logic     aw_empty;
    logic     w_full;
    logic     w_empty;
    logic     ar_full;
    logic     ar_empty;

    ////////////////////
    // Write address
    ////////////////////

    chan_fifo #(.DATA_W($bits(ax_chan_t)), .DEPTH(AX_DEPTH)) aw_fifo (
        .i_aclk  (i_aclk),
        .i_reset (i_reset),
        .i_push  (i_sw_awvalid),
        .i_data  (i_sw_aw),
        .o_full  (aw_full),
        .i_pull  (i_m_awready),
        .o_data  (aw_q),
        .o_empty (aw_empty)
    );

    assign o_sw_awready = ~aw_full;
    assign o_m_awvalid  = ~aw_empty;
    assign o_m_awaddr   = aw_q.addr;
    assign o_m_awprot   = aw_q.prot;
    assign o_m_awid     = aw_q.id;

    ////////////////////
    // Write data
    ////////////////////

    chan_fifo #(.DATA_W($bits(w_chan_t)), .DEPTH(W_DEPTH)) w_fifo (
        .i_aclk  (i_aclk),
        .i_reset (i_reset),
        .i_push  (i_sw_wvalid),
        .i_data  (i_sw_w),
        .o_full  (w_full),
        .i_pull  (i_m_wready),
        .o_data  (w_q),
        .o_empty (w_empty)
    );

    assign o_sw_wready = ~w_full;
    assign o_m_wvalid  = ~w_empty;
    assign o_m_wdata   = w_q.data;
    assign o_m_wstrb   = w_q.strb;
    assign o_m_wlast   = w_q.last;

    ////////////////////
    // Read address
    ////////////////////

    chan_fifo #(.DATA_W($bits(ax_chan_t)), .DEPTH(AX_DEPTH)) ar_fifo (
        .i_aclk  (i_aclk),
        .i_reset (i_reset),
        .i_push  (i_sw_arvalid),
        .i_data  (i_sw_ar),
        .o_full  (ar_full),
        .i_pull  (i_m_arready),
        .o_data  (ar_q),
        .o_empty (ar_empty)
    );

    assign o_sw_arready = ~ar_full;
    assign o_m_arvalid  = ~ar_empty;
    assign o_m_araddr   = ar_q.addr;
    assign o_m_arprot   = ar_q.prot;
    assign o_m_arid     = ar_q.id;

    // AXI4-lite bursts are single beats, so each accepted beat closes its burst
    a_wlast_set: assert property (@(posedge i_aclk) disable iff (i_reset)
        (i_sw_wvalid && o_sw_wready) |-> i_sw_w.last);

endmodule

// ==== hdl/chan_fifo.sv ====
// Single-clock FIFO holding the words of one AXI channel
// Push and pull are qualified inside by the full and empty flags
module chan_fifo #(
    parameter int DATA_W = 8,
    parameter int DEPTH  = 4
) (
    input  logic              i_aclk,
    input  logic              i_reset,
    input  logic              i_push,
    input  logic [DATA_W-1:0] i_data,
    output logic              o_full,
    input  logic              i_pull,
    output logic [DATA_W-1:0] o_data,
    output logic              o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push_ok;
    logic              pull_ok;

    // Wraps at DEPTH so non power-of-two depths work too
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ok = i_push & ~o_full;
    assign pull_ok = i_pull & ~o_empty;

    ////////////////////
    // Pointers and fill level
    ////////////////////

    always_ff @(posedge i_aclk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pull_ok) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push_ok, pull_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge i_aclk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Head word shows as soon as it is written
    assign o_data  = mem[rd_ptr];
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);

    ////////////////////
    // Checks
    ////////////////////

    a_count_range: assert property (@(posedge i_aclk) disable iff (i_reset)
        count <= CNT_W'(DEPTH));

    // Reader sees a stable head until it takes it
    a_head_stable: assert property (@(posedge i_aclk) disable iff (i_reset)
        (!o_empty && !i_pull) |=> $stable(o_data));

endmodule

// ==== hdl/mst_if_pkg.sv ====
// AXI4-lite widths, response codes and channel words shared by the master port
// Import into any block that handles switch-side channel words
package mst_if_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    localparam int AXI_ADDR_W = 16;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    ////////////////////
    // Response codes
    ////////////////////

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    ////////////////////
    // Channel words
    ////////////////////

    // Shared by AW and AR
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [2:0]            prot;
        logic [AXI_ID_W-1:0]   id;
    } ax_chan_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } w_chan_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [1:0]          resp;
    } b_chan_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } r_chan_t;

endpackage
